/* common/rx_buf_pkg.sv */
/*
 * rx buffer shared definitions
 * widths, depths and vector types for the pre-decimation sample RAM
 * and the decimated-sample FIFO, plus the fill indicator encoding
 */

package rx_buf_pkg;

    // --------------------------------------------------
    // sample and memory geometry
    // --------------------------------------------------
    localparam int SAMPLE_W   = 16;
    localparam int RAM_DEPTH  = 512;
    localparam int RAM_AW     = 9;
    localparam int FIFO_DEPTH = 512;
    localparam int FIFO_PW    = 9;

    // level needs one extra bit to reach a full count of 512
    localparam int LEVEL_W    = FIFO_PW + 1;
    localparam int FLAG_W     = 4;

    // --------------------------------------------------
    // vector types
    // --------------------------------------------------
    // one mono audio sample
    typedef logic [SAMPLE_W-1:0] sample_t;
    // address into the sample RAM
    typedef logic [RAM_AW-1:0]   ram_addr_t;
    // FIFO read and write pointers
    typedef logic [FIFO_PW-1:0]  fifo_ptr_t;
    // FIFO occupancy, 0 to 512
    typedef logic [LEVEL_W-1:0]  fifo_level_t;
    // coarse fill indicator
    typedef logic [FLAG_W-1:0]   fill_flag_t;

    // --------------------------------------------------
    // fill indicator encoding
    // --------------------------------------------------
    localparam fill_flag_t FLAG_EMPTY      = 4'd0;
    localparam fill_flag_t FLAG_FULL       = 4'd15;
    // partial levels step once every 64 words
    localparam int         FLAG_STEP_SHIFT = 6;

    // write address after reset, first sample wraps to 0
    localparam ram_addr_t  WADDR_RESET     = 9'd511;

endpackage

/* predeci/predeci_ram_writer.sv */
/*
 * pre-decimation RAM writer
 * auto-incrementing write address and registered write enable for
 * incoming samples, with a register-side override that clears words
 */

`timescale 1ns/100ps

module predeci_ram_writer
    import rx_buf_pkg::*;
(
    input  logic      WBs_CLK_i,
    input  logic      WBs_RST_i,
    input  sample_t   sample_i,
    input  logic      sample_wr_i,
    input  logic      wb_clr_master_i,
    input  ram_addr_t wb_clr_addr_i,
    input  logic      wb_clr_wen_i,
    output ram_addr_t ram_waddr_o,
    output sample_t   ram_wdata_o,
    output logic      ram_wen_o,
    output ram_addr_t seq_waddr_o
);

    ram_addr_t seq_addr_r;
    logic      seq_wen_r;
    sample_t   sample_r;

    // --------------------------------------------------
    // sequential sample write
    // --------------------------------------------------
    // address advances on every strobe, override or not
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            seq_addr_r <= WADDR_RESET;
            seq_wen_r  <= 1'b0;
        end
        else
        begin
            if (sample_wr_i)
            begin
                seq_addr_r <= seq_addr_r + 1'b1;
            end
            // one-cycle enable per strobe
            seq_wen_r <= sample_wr_i;
        end
    end

    // sample captured alongside the address step
    always_ff @(posedge WBs_CLK_i)
    begin
        if (sample_wr_i)
        begin
            sample_r <= sample_i;
        end
    end

    // --------------------------------------------------
    // write port select
    // --------------------------------------------------
    // register master clears with zeros, no added delay
    assign ram_waddr_o = wb_clr_master_i ? wb_clr_addr_i : seq_addr_r;
    assign ram_wdata_o = wb_clr_master_i ? sample_t'(0) : sample_r;
    assign ram_wen_o   = wb_clr_master_i ? wb_clr_wen_i : seq_wen_r;

    assign seq_waddr_o = seq_addr_r;

endmodule

/* predeci/predeci_sample_ram.sv */
/*
 * pre-decimation sample RAM
 * 512 x 16 memory with one synchronous write port and one
 * registered read port for the FIR engine
 */

`timescale 1ns/100ps

module predeci_sample_ram
    import rx_buf_pkg::*;
(
    input  logic      WBs_CLK_i,
    input  ram_addr_t ram_waddr_i,
    input  sample_t   ram_wdata_i,
    input  logic      ram_wen_i,
    input  ram_addr_t ram_raddr_i,
    output sample_t   ram_rdata_o
);

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    // contents undefined until written
    sample_t mem [RAM_DEPTH];
    sample_t rdata_r;

    // write port
    always_ff @(posedge WBs_CLK_i)
    begin
        if (ram_wen_i)
        begin
            mem[ram_waddr_i] <= ram_wdata_i;
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------
    // data appears one edge after the address
    // same-address collision returns the old word
    always_ff @(posedge WBs_CLK_i)
    begin
        rdata_r <= mem[ram_raddr_i];
    end

    assign ram_rdata_o = rdata_r;

endmodule

/* verilog/deci_sample_fifo.sv */
/*
 * decimated-sample FIFO
 * 512 x 16 first-word-fall-through buffer with flush, registered
 * occupancy, empty and full flags and a 4-bit fill indicator
 */

`timescale 1ns/100ps

module deci_sample_fifo
    import rx_buf_pkg::*;
(
    input  logic        WBs_CLK_i,
    input  logic        WBs_RST_i,
    input  logic        flush_i,
    input  logic        push_i,
    input  sample_t     push_data_i,
    input  logic        pop_i,
    output sample_t     pop_data_o,
    output logic        empty_o,
    output logic        full_o,
    output fifo_level_t level_o,
    output fill_flag_t  fill_flag_o
);

    sample_t     mem [FIFO_DEPTH];
    fifo_ptr_t   wr_ptr_r;
    fifo_ptr_t   rd_ptr_r;
    fifo_level_t level_r;
    fifo_level_t level_nxt;
    logic        empty_r;
    logic        full_r;
    fill_flag_t  flag_r;
    logic        do_push;
    logic        do_pop;

    // coarse indicator from an occupancy value
    function automatic fill_flag_t level_to_flag(input fifo_level_t lvl);
        fill_flag_t flag;
        if (lvl == '0)
        begin
            flag = FLAG_EMPTY;
        end
        else if (lvl == fifo_level_t'(FIFO_DEPTH))
        begin
            flag = FLAG_FULL;
        end
        else
        begin
            // 1 to 511 maps onto 1 to 8
            flag = fill_flag_t'(lvl >> FLAG_STEP_SHIFT) + 1'b1;
        end
        return flag;
    endfunction

    // --------------------------------------------------
    // overrun and underrun guards
    // --------------------------------------------------
    // push when full and pop when empty are dropped
    assign do_push = push_i & ~full_r & ~flush_i;
    assign do_pop  = pop_i & ~empty_r & ~flush_i;

    // next occupancy
    always_comb
    begin
        case ({do_pop, do_push})
            2'b01:   level_nxt = level_r + 1'b1;
            2'b10:   level_nxt = level_r - 1'b1;
            // idle or push with pop, level holds
            default: level_nxt = level_r;
        endcase
    end

    // --------------------------------------------------
    // pointers, level and flags
    // --------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            level_r  <= '0;
            empty_r  <= 1'b1;
            full_r   <= 1'b0;
            flag_r   <= FLAG_EMPTY;
        end
        else if (flush_i)
        begin
            // flush beats a push or pop at the same edge
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            level_r  <= '0;
            empty_r  <= 1'b1;
            full_r   <= 1'b0;
            flag_r   <= FLAG_EMPTY;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            level_r <= level_nxt;
            // flags track the new level at the same edge
            empty_r <= (level_nxt == '0);
            full_r  <= (level_nxt == fifo_level_t'(FIFO_DEPTH));
            flag_r  <= level_to_flag(level_nxt);
        end
    end

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    always_ff @(posedge WBs_CLK_i)
    begin
        if (do_push)
        begin
            mem[wr_ptr_r] <= push_data_i;
        end
    end

    // head word falls through, zero while empty
    assign pop_data_o  = empty_r ? sample_t'(0) : mem[rd_ptr_r];

    assign empty_o     = empty_r;
    assign full_o      = full_r;
    assign level_o     = level_r;
    assign fill_flag_o = flag_r;

endmodule

/* verilog/i2s_rx_buffers.sv */
/*
 * I2S receive buffers
 * sample RAM ahead of the FIR decimator, with its writer and
 * register-side clear, plus the FIFO for decimated output samples
 */

`timescale 1ns/100ps

module i2s_rx_buffers
    import rx_buf_pkg::*;
(
    input  logic        WBs_CLK_i,
    input  logic        WBs_RST_i,

    // incoming mono samples
    input  sample_t     sample_i,
    input  logic        sample_wr_i,

    // register-side RAM clear
    input  logic        wb_clr_master_i,
    input  ram_addr_t   wb_clr_addr_i,
    input  logic        wb_clr_wen_i,

    // FIR read port
    input  ram_addr_t   fir_raddr_i,
    output sample_t     fir_rdata_o,

    // write side status
    output ram_addr_t   predeci_waddr_o,
    output logic        predeci_wen_o,

    // decimated sample FIFO
    input  sample_t     deci_data_i,
    input  logic        deci_push_i,
    input  logic        deci_pop_i,
    input  logic        deci_flush_i,
    output sample_t     deci_data_o,
    output logic        deci_empty_o,
    output logic        deci_full_o,
    output fifo_level_t deci_level_o,
    output fill_flag_t  deci_fill_flag_o
);

    ram_addr_t ram_waddr;
    sample_t   ram_wdata;

    // --------------------------------------------------
    // pre-decimation sample path
    // --------------------------------------------------
    // write enable seen by the RAM also goes out as status
    predeci_ram_writer u_writer (
        .WBs_CLK_i       (WBs_CLK_i),
        .WBs_RST_i       (WBs_RST_i),
        .sample_i        (sample_i),
        .sample_wr_i     (sample_wr_i),
        .wb_clr_master_i (wb_clr_master_i),
        .wb_clr_addr_i   (wb_clr_addr_i),
        .wb_clr_wen_i    (wb_clr_wen_i),
        .ram_waddr_o     (ram_waddr),
        .ram_wdata_o     (ram_wdata),
        .ram_wen_o       (predeci_wen_o),
        .seq_waddr_o     (predeci_waddr_o)
    );

    // FIR engine addresses the RAM directly
    predeci_sample_ram u_sample_ram (
        .WBs_CLK_i   (WBs_CLK_i),
        .ram_waddr_i (ram_waddr),
        .ram_wdata_i (ram_wdata),
        .ram_wen_i   (predeci_wen_o),
        .ram_raddr_i (fir_raddr_i),
        .ram_rdata_o (fir_rdata_o)
    );

    // --------------------------------------------------
    // decimated sample FIFO
    // --------------------------------------------------
    deci_sample_fifo u_deci_fifo (
        .WBs_CLK_i   (WBs_CLK_i),
        .WBs_RST_i   (WBs_RST_i),
        .flush_i     (deci_flush_i),
        .push_i      (deci_push_i),
        .push_data_i (deci_data_i),
        .pop_i       (deci_pop_i),
        .pop_data_o  (deci_data_o),
        .empty_o     (deci_empty_o),
        .full_o      (deci_full_o),
        .level_o     (deci_level_o),
        .fill_flag_o (deci_fill_flag_o)
    );

endmodule

/* verif/rx_buffers_assertions.sv */
/*
 * rx buffer assertions
 * bound into the decimated FIFO and the RAM writer
 */

`timescale 1ns/100ps

module rx_buffers_assertions
    import rx_buf_pkg::*;
(
    input logic        clk_i,
    input logic        rst_i,
    input logic        empty_i,
    input logic        full_i,
    input fifo_level_t level_i,
    input logic        flush_i,
    input logic        sample_wr_i,
    input logic        clr_master_i,
    input logic        wen_i
);

    // --------------------------------------------------
    // FIFO flags and level
    // --------------------------------------------------
    a_not_empty_and_full: assert property (
        @(posedge clk_i) disable iff (rst_i) !(empty_i && full_i))
        else $error("empty and full asserted together");

    a_level_in_range: assert property (
        @(posedge clk_i) disable iff (rst_i) level_i <= fifo_level_t'(FIFO_DEPTH))
        else $error("FIFO level above depth");

    // flush always lands on an empty FIFO
    a_flush_clears: assert property (
        @(posedge clk_i) disable iff (rst_i) flush_i |=> (level_i == '0))
        else $error("level not zero after flush");

    // --------------------------------------------------
    // writer enable
    // --------------------------------------------------
    // override may grab the port on the following edge
    a_strobe_gives_wen: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (sample_wr_i && !clr_master_i) |=> (clr_master_i || wen_i))
        else $error("write strobe without write enable");

endmodule

bind deci_sample_fifo rx_buffers_assertions u_fifo_assert (
    .clk_i        (WBs_CLK_i),
    .rst_i        (WBs_RST_i),
    .empty_i      (empty_o),
    .full_i       (full_o),
    .level_i      (level_o),
    .flush_i      (flush_i),
    .sample_wr_i  (1'b0),
    .clr_master_i (1'b0),
    .wen_i        (1'b0)
);

bind predeci_ram_writer rx_buffers_assertions u_writer_assert (
    .clk_i        (WBs_CLK_i),
    .rst_i        (WBs_RST_i),
    .empty_i      (1'b0),
    .full_i       (1'b0),
    .level_i      (10'd0),
    .flush_i      (1'b0),
    .sample_wr_i  (sample_wr_i),
    .clr_master_i (wb_clr_master_i),
    .wen_i        (ram_wen_o)
);

/* verif/tb_i2s_rx_buffers.sv */
/*
 * testbench for the I2S receive buffers
 * runs commands from a stimulus file against RAM and FIFO models
 */

`timescale 1ns/100ps

module tb_i2s_rx_buffers
    import rx_buf_pkg::*;
;

    logic        clk;
    logic        rst;
    sample_t     sample;
    logic        sample_wr;
    logic        clr_master;
    ram_addr_t   clr_addr;
    logic        clr_wen;
    ram_addr_t   fir_raddr;
    sample_t     fir_rdata;
    ram_addr_t   waddr;
    logic        wen;
    sample_t     deci_din;
    logic        deci_push;
    logic        deci_pop;
    logic        deci_flush;
    sample_t     deci_dout;
    logic        deci_empty;
    logic        deci_full;
    fifo_level_t deci_level;
    fill_flag_t  deci_flag;

    // reference models
    sample_t     ram_model [RAM_DEPTH];
    int          wr_count;
    sample_t     fifo_q [$];
    integer      seed;
    int          cycles;
    int          cycle_limit;
    int          errors;

    i2s_rx_buffers dut0 (
        .WBs_CLK_i        (clk),
        .WBs_RST_i        (rst),
        .sample_i         (sample),
        .sample_wr_i      (sample_wr),
        .wb_clr_master_i  (clr_master),
        .wb_clr_addr_i    (clr_addr),
        .wb_clr_wen_i     (clr_wen),
        .fir_raddr_i      (fir_raddr),
        .fir_rdata_o      (fir_rdata),
        .predeci_waddr_o  (waddr),
        .predeci_wen_o    (wen),
        .deci_data_i      (deci_din),
        .deci_push_i      (deci_push),
        .deci_pop_i       (deci_pop),
        .deci_flush_i     (deci_flush),
        .deci_data_o      (deci_dout),
        .deci_empty_o     (deci_empty),
        .deci_full_o      (deci_full),
        .deci_level_o     (deci_level),
        .deci_fill_flag_o (deci_flag)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // --------------------------------------------------
    // timeout
    // --------------------------------------------------
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // one clock, inputs change 10 ns after the edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "first error");
        end
    endtask

    // fill indicator as defined for the FIFO
    function automatic int expected_flag(input int lvl);
        if (lvl == 0)
            return 0;
        else if (lvl == 512)
            return 15;
        else
            return 1 + lvl / 64;
    endfunction

    task automatic check_fifo();
        int n;
        n = fifo_q.size();
        check_val(32'(deci_level), 32'(n), "FIFO level");
        check_val(32'(deci_flag), 32'(expected_flag(n)), "fill flag");
        check_val(32'(deci_empty), 32'(n == 0), "empty flag");
        check_val(32'(deci_full), 32'(n == 512), "full flag");
        if (n == 0)
            check_val(32'(deci_dout), 32'd0, "FIFO data while empty");
        else
            check_val(32'(deci_dout), 32'(fifo_q[0]), "FIFO head data");
    endtask

    // --------------------------------------------------
    // command interpreter
    // --------------------------------------------------
    initial
    begin
        int    fd;
        int    code;
        int    n;
        int    i;
        int    f;
        int    fl;
        int    em;
        string cmd;
        string line;
        logic  pop_ok;
        logic  push_ok;

        seed        = 32'heec4;
        cycles      = 0;
        cycle_limit = 100000;
        errors      = 0;
        wr_count    = 0;
        rst         = 1'b1;
        sample      = '0;
        sample_wr   = 1'b0;
        clr_master  = 1'b0;
        clr_addr    = '0;
        clr_wen     = 1'b0;
        fir_raddr   = '0;
        deci_din    = '0;
        deci_push   = 1'b0;
        deci_pop    = 1'b0;
        deci_flush  = 1'b0;

        fd = $fopen("verif/rx_buffers_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file");
            $display("Testbench failed");
            $fatal(1, "no stimulus");
        end

        step();
        step();
        rst = 1'b0;

        while (!$feof(fd))
        begin
            code = $fscanf(fd, "%s", cmd);
            if (code != 1)
                break;
            if (cmd.substr(0, 0) == "#")
            begin
                code = $fgets(line, fd);
            end
            else if (cmd == "CYCLES")
            begin
                code = $fscanf(fd, "%d", n);
                cycle_limit = 2 * n + 200;
            end
            else if (cmd == "RSTCHK")
            begin
                check_val(32'(wen), 32'd0, "write enable after reset");
                check_fifo();
            end
            else if (cmd == "WR")
            begin
                code = $fscanf(fd, "%d", n);
                for (i = 0; i < n; i++)
                begin
                    sample    = 16'($random(seed));
                    sample_wr = 1'b1;
                    ram_model[wr_count % 512] = sample;
                    wr_count++;
                    step();
                    // sample n goes to address n mod 512
                    check_val(32'(waddr), 32'((wr_count - 1) % 512), "write address");
                    check_val(32'(wen), 32'd1, "write enable after strobe");
                end
                sample_wr = 1'b0;
                // last sample lands one edge later
                step();
                check_val(32'(wen), 32'd0, "write enable after last sample");
            end
            else if (cmd == "RDN")
            begin
                code = $fscanf(fd, "%d", n);
                for (i = 0; i < n; i++)
                begin
                    fir_raddr = ram_addr_t'(i % 512);
                    step();
                    check_val(32'(fir_rdata), 32'(ram_model[i % 512]), "FIR read data");
                end
            end
            else if (cmd == "CLR")
            begin
                code = $fscanf(fd, "%d", n);
                clr_master = 1'b1;
                clr_addr   = ram_addr_t'(n);
                clr_wen    = 1'b1;
                ram_model[n] = '0;
                step();
                clr_wen    = 1'b0;
                clr_master = 1'b0;
            end
            else if (cmd == "PUSH" || cmd == "POP" || cmd == "PP")
            begin
                code = $fscanf(fd, "%d", n);
                for (i = 0; i < n; i++)
                begin
                    check_fifo();
                    deci_din  = 16'($random(seed));
                    deci_push = (cmd != "POP");
                    deci_pop  = (cmd != "PUSH");
                    // overrun and underrun are dropped
                    pop_ok  = deci_pop && (fifo_q.size() > 0);
                    push_ok = deci_push && (fifo_q.size() < 512);
                    if (pop_ok)
                        void'(fifo_q.pop_front());
                    if (push_ok)
                        fifo_q.push_back(deci_din);
                    step();
                    check_fifo();
                end
                deci_push = 1'b0;
                deci_pop  = 1'b0;
            end
            else if (cmd == "FLUSHPUSH")
            begin
                deci_flush = 1'b1;
                deci_push  = 1'b1;
                deci_din   = 16'($random(seed));
                fifo_q.delete();
                step();
                deci_flush = 1'b0;
                deci_push  = 1'b0;
                check_fifo();
            end
            else if (cmd == "LVL")
            begin
                code = $fscanf(fd, "%d %d %d %d", n, f, fl, em);
                check_val(32'(deci_level), 32'(n), "level against file");
                check_val(32'(deci_flag), 32'(f), "flag against file");
                check_val(32'(deci_full), 32'(fl), "full against file");
                check_val(32'(deci_empty), 32'(em), "empty against file");
            end
            else
            begin
                $display("unknown command in stimulus file: %s", cmd);
                errors++;
                break;
            end
        end
        $fclose(fd);

        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verif/rx_buffers_stim.txt */
# command operands; LVL takes level flag full empty
# WR/RDN/PUSH/POP/PP take a count, CLR takes an address
CYCLES 2800
RSTCHK
WR 20
RDN 20
WR 494
RDN 514
CLR 5
CLR 100
CLR 300
RDN 514
PUSH 10
LVL 10 1 0 0
PP 5
POP 4
LVL 6 1 0 0
PUSH 506
LVL 512 15 1 0
PUSH 1
LVL 512 15 1 0
PP 3
POP 512
LVL 0 0 0 1
POP 1
LVL 0 0 0 1
PUSH 70
LVL 70 2 0 0
FLUSHPUSH
LVL 0 0 0 1

/* sources.f */
common/rx_buf_pkg.sv
predeci/predeci_ram_writer.sv
predeci/predeci_sample_ram.sv
verilog/deci_sample_fifo.sv
verilog/i2s_rx_buffers.sv
verif/rx_buffers_assertions.sv
verif/tb_i2s_rx_buffers.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_i2s_rx_buffers
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf $(OBJDIR)
